// File: if_stage.f
verilog/if_pkg.sv
verilog/pc_select.sv
verilog/fetch_fifo.sv
verilog/prefetch_buffer.sv
verilog/if_id_regs.sv
verilog/if_stage.sv
tb/if_stage_assertions.sv
tb/if_stage_tb.sv

// File: tb/if_stage_assertions.sv
/*
 * fetch stage port checks
 * bound into the fetch stage top level
 */

`timescale 1ns/100ps

module if_stage_assertions (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     instr_req_o,
  input logic [if_pkg::AddrW-1:0] instr_addr_o,
  input logic                     instr_valid_id_o,
  input logic                     instr_new_id_o
);

  // read by the testbench at the end of the run
  int   fail_cnt = 0;
  // first instruction has reached decode
  logic seen_new_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_new_q <= 1'b0;
    end else if (instr_new_id_o) begin
      seen_new_q <= 1'b1;
    end
  end

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_req_o |-> (instr_addr_o[1:0] == 2'b00))
    else begin
      fail_cnt++;
      $error("instruction request address is not word aligned");
    end

  addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_req_o |-> !$isunknown(instr_addr_o))
    else begin
      fail_cnt++;
      $error("instruction request address is unknown");
    end

  new_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_new_id_o |-> instr_valid_id_o)
    else begin
      fail_cnt++;
      $error("new instruction flagged without valid");
    end

  // nothing valid in decode before the first fetch arrives
  no_early_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!seen_new_q && !instr_new_id_o) |-> !instr_valid_id_o)
    else begin
      fail_cnt++;
      $error("decode valid before any instruction was fetched");
    end

endmodule

bind if_stage if_stage_assertions u_if_stage_assertions (.*);

// File: tb/if_stage_tb.sv
/*
 * testbench for the instruction fetch stage
 * memory model with random grant and response delay, reference
 * checking of every instruction that reaches decode
 */

`timescale 1ns/100ps

module if_stage_tb;

  import if_pkg::*;

  localparam int unsigned ClkPeriod   = 20;
  localparam logic [31:0] HaltAddr    = 32'h1A11_0800;
  localparam logic [31:0] DbgExcAddr  = 32'h1A11_0808;
  localparam int unsigned Depth       = 3;
  // memory contents are the address xor this pattern
  localparam logic [31:0] DataPattern = 32'h5A3C_96E1;
  // bus error window of four words
  localparam logic [31:0] ErrLo       = 32'h0000_2000;
  localparam logic [31:0] ErrHi       = 32'h0000_2010;
  // instructions waited for over all tests
  localparam int TotalInstr     = 140;
  localparam int CyclesPerInstr = 40;
  localparam int WatchdogCycles = TotalInstr * CyclesPerInstr + 500;

  logic              clk_i;
  logic              rst_ni;
  logic [31:0]       boot_addr_i;
  logic              req_i;
  logic              instr_req_o;
  logic [31:0]       instr_addr_o;
  logic              instr_gnt_i;
  logic              instr_rvalid_i;
  logic [31:0]       instr_rdata_i;
  logic              instr_bus_err_i;
  logic              instr_valid_id_o;
  logic              instr_new_id_o;
  logic [31:0]       instr_rdata_id_o;
  logic              instr_fetch_err_o;
  logic [31:0]       pc_if_o;
  logic [31:0]       pc_id_o;
  logic              instr_valid_clear_i;
  logic              pc_set_i;
  pc_sel_e           pc_mux_i;
  exc_pc_sel_e       exc_pc_mux_i;
  logic [4:0]        exc_cause_i;
  logic              exc_irq_int_i;
  logic [31:0]       branch_target_i;
  logic [31:0]       pc_set_target_o;
  logic [31:0]       csr_mepc_i;
  logic [31:0]       csr_depc_i;
  logic [31:0]       csr_mtvec_i;
  logic              csr_mtvec_init_o;
  logic              id_in_ready_i;
  logic              pc_mismatch_alert_o;
  logic              if_busy_o;

  // bookkeeping
  int          err_cnt = 0;
  int          check_cnt = 0;
  int          test_cnt = 0;
  int          test_err_start = 0;
  string       test_name;
  int          total_err;
  int          new_cnt = 0;
  logic [31:0] exp_pc = '0;
  logic [31:0] redirect_pc = '0;
  logic        last_valid = 1'b0;
  logic        last_clear = 1'b0;
  logic [31:0] last_pc_if = '0;
  // granted requests still waiting for their response
  int          exp_outstanding = 0;
  // decode side stimulus modes
  logic        bp_en = 1'b0;
  logic        clear_en = 1'b0;
  logic        ready_state = 1'b1;
  int          hold_cnt = 0;
  // memory model state
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q [$];
  int          mem_cycle = 0;
  int          last_due = 0;
  int          due;

  if_stage #(
    .DmHaltAddr      (HaltAddr),
    .DmExceptionAddr (DbgExcAddr),
    .FifoDepth       (Depth)
  ) UUT (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return addr ^ DataPattern;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ErrLo) && (addr < ErrHi);
  endfunction

  // next fetch address as the pc mux rules define it
  function automatic logic [31:0] expected_target(input pc_sel_e mux,
      input exc_pc_sel_e exc_mux, input logic [4:0] cause, input logic irq_int);
    logic [31:0] vec;
    logic [31:0] exc;
    logic [31:0] pc;
    vec = irq_int ? 32'd31 : {27'd0, cause};
    case (exc_mux)
      EXC_PC_EXC: exc = csr_mtvec_i & ~32'h3;
      // one word per vector with bit 7 left clear
      EXC_PC_IRQ: exc = (csr_mtvec_i & 32'hFFFF_FF00) + vec * 4;
      EXC_PC_DBD: exc = HaltAddr;
      default:    exc = DbgExcAddr;
    endcase
    case (mux)
      PC_BOOT: pc = boot_addr_i;
      PC_JUMP: pc = branch_target_i;
      PC_EXC:  pc = exc;
      PC_ERET: pc = csr_mepc_i;
      default: pc = csr_depc_i;
    endcase
    return pc & ~32'h3;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // grants are sampled mid cycle and answered in order 1 to 3 cycles later
  always begin
    @(negedge clk_i);
    if (!rst_ni) begin
      rsp_addr_q.delete();
      rsp_due_q.delete();
      last_due = 0;
    end else if (instr_req_o && instr_gnt_i) begin
      due = mem_cycle + 1 + int'($urandom % 3);
      // one response per cycle at most
      if (due <= last_due) begin
        due = last_due + 1;
      end
      rsp_addr_q.push_back(instr_addr_o);
      rsp_due_q.push_back(due);
      last_due = due;
    end
    @(posedge clk_i);
    #1;
    mem_cycle++;
    instr_gnt_i = ($urandom % 3) != 0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= mem_cycle) begin
      instr_rvalid_i  = 1'b1;
      instr_rdata_i   = ref_word(rsp_addr_q[0]);
      instr_bus_err_i = in_err_window(rsp_addr_q[0]);
      void'(rsp_addr_q.pop_front());
      void'(rsp_due_q.pop_front());
    end else begin
      instr_rvalid_i  = 1'b0;
      instr_rdata_i   = '0;
      instr_bus_err_i = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // comparison
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni) begin
      last_valid = 1'b0;
      last_clear = 1'b0;
      last_pc_if = '0;
      exp_outstanding = 0;
    end else begin
      // old stream entries still land before the redirect takes over
      if (instr_new_id_o) begin
        // head address in the cycle the entry was taken
        check_value("pc_if_o", last_pc_if, exp_pc);
        check_value("pc_id_o", pc_id_o, exp_pc);
        check_value("instr_rdata_id_o", instr_rdata_id_o, ref_word(exp_pc));
        check_value("instr_fetch_err_o", instr_fetch_err_o, in_err_window(exp_pc));
        exp_pc = exp_pc + 32'd4;
        new_cnt++;
      end
      // valid sticks until cleared
      if (last_valid && !last_clear) begin
        check_value("instr_valid_id_o", instr_valid_id_o, 1'b1);
      end
      // clear with no new entry drops valid
      if (last_clear && !instr_new_id_o) begin
        check_value("instr_valid_id_o", instr_valid_id_o, 1'b0);
      end
      check_value("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
      // busy while any granted request has no response yet
      check_value("if_busy_o", if_busy_o, exp_outstanding != 0);
      exp_outstanding = exp_outstanding + int'(instr_req_o && instr_gnt_i) -
                        int'(instr_rvalid_i);
      if (pc_set_i) begin
        exp_pc = redirect_pc;
      end
      last_valid = instr_valid_id_o;
      last_clear = instr_valid_clear_i;
      last_pc_if = pc_if_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // one cycle of decode side activity
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    pc_set_i = 1'b0;
    if (bp_en) begin
      if (hold_cnt == 0) begin
        ready_state = ~ready_state;
        hold_cnt = ready_state ? $urandom % 4 : 4 + $urandom % 12;
      end else begin
        hold_cnt--;
      end
      id_in_ready_i = ready_state;
    end else begin
      id_in_ready_i = 1'b1;
    end
    instr_valid_clear_i = clear_en && ($urandom % 3 == 0);
  endtask

  task automatic wait_new(input int n);
    int target;
    int cycles;
    target = new_cnt + n;
    cycles = 0;
    while (new_cnt < target && cycles < n * CyclesPerInstr) begin
      next_cycle();
      cycles++;
    end
    if (new_cnt < target) begin
      err_cnt++;
      $display("ERROR at %0t ns: only %0d of %0d instructions reached decode in time",
               $time, n - (target - new_cnt), n);
    end
  endtask

  // pc set pulse with the target checked in the same cycle
  task automatic redirect(input pc_sel_e mux, input exc_pc_sel_e exc_mux,
      input logic [4:0] cause, input logic irq_int);
    logic [31:0] target;
    next_cycle();
    req_i         = 1'b1;
    pc_mux_i      = mux;
    exc_pc_mux_i  = exc_mux;
    exc_cause_i   = cause;
    exc_irq_int_i = irq_int;
    target        = expected_target(mux, exc_mux, cause, irq_int);
    redirect_pc   = target;
    pc_set_i      = 1'b1;
    @(negedge clk_i);
    check_value("pc_set_target_o", pc_set_target_o, target);
    check_value("instr_addr_o", instr_addr_o, target);
    check_value("csr_mtvec_init_o", csr_mtvec_init_o, mux == PC_BOOT);
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = err_cnt;
    test_cnt++;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err_start) begin
      $display("test %0d (%s) done, no errors", test_cnt, test_name);
    end else begin
      $display("test %0d (%s) done, %0d errors", test_cnt, test_name,
               err_cnt - test_err_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(9));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    boot_addr_i = 32'h0000_1000;
    req_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_bus_err_i = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exc_cause_i = '0;
    exc_irq_int_i = 1'b0;
    branch_target_i = '0;
    csr_mepc_i = '0;
    csr_depc_i = '0;
    // low bits hold the mode field and are not part of the base
    csr_mtvec_i = 32'h0000_4001;
    id_in_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_test("boot and sequential fetch");
    check_value("instr_req_o", instr_req_o, 1'b0);
    check_value("instr_valid_id_o", instr_valid_id_o, 1'b0);
    check_value("instr_new_id_o", instr_new_id_o, 1'b0);
    check_value("csr_mtvec_init_o", csr_mtvec_init_o, 1'b0);
    check_value("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
    check_value("if_busy_o", if_busy_o, 1'b0);
    redirect(PC_BOOT, EXC_PC_EXC, 5'd0, 1'b0);
    next_cycle();
    @(negedge clk_i);
    // init strobe is a single cycle pulse
    check_value("csr_mtvec_init_o", csr_mtvec_init_o, 1'b0);
    wait_new(16);
    finish_test();

    start_test("back-pressure");
    bp_en = 1'b1;
    wait_new(40);
    bp_en = 1'b0;
    finish_test();

    start_test("redirects");
    branch_target_i = 32'h0000_3006;
    csr_mepc_i      = 32'h0000_5003;
    csr_depc_i      = 32'h0000_6ABE;
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 1'b0);
    wait_new(8);
    redirect(PC_ERET, EXC_PC_EXC, 5'd0, 1'b0);
    wait_new(8);
    redirect(PC_DRET, EXC_PC_EXC, 5'd0, 1'b0);
    wait_new(8);
    finish_test();

    start_test("exception targets");
    redirect(PC_EXC, EXC_PC_EXC, 5'd0, 1'b0);
    wait_new(6);
    redirect(PC_EXC, EXC_PC_IRQ, 5'($urandom % 32), 1'b0);
    wait_new(6);
    // internal interrupt overrides the cause
    redirect(PC_EXC, EXC_PC_IRQ, 5'($urandom % 32), 1'b1);
    wait_new(6);
    redirect(PC_EXC, EXC_PC_DBD, 5'd0, 1'b0);
    wait_new(6);
    redirect(PC_EXC, EXC_PC_DBG_EXC, 5'd0, 1'b0);
    wait_new(6);
    finish_test();

    start_test("bus error");
    // run through the window from two words below it
    branch_target_i = 32'h0000_1FF9;
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, 1'b0);
    wait_new(10);
    finish_test();

    start_test("valid clear and pc check");
    clear_en = 1'b1;
    wait_new(20);
    clear_en = 1'b0;
    next_cycle();
    next_cycle();
    finish_test();

    total_err = err_cnt + UUT.u_if_stage_assertions.fail_cnt;
    $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             test_cnt, check_cnt, err_cnt, UUT.u_if_stage_assertions.fail_cnt);
    if (total_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog sized from the number of instructions waited for
  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("ERROR: watchdog expired after %0d cycles, fetch stage made no progress",
             WatchdogCycles);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: verilog/fetch_fifo.sv
/*
 * fetch FIFO
 * queues fetched words with their address and bus error flag
 * and restarts at a new address on flush
 */

`timescale 1ns/100ps

module fetch_fifo #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  input  logic                             in_valid_i,
  input  logic [if_pkg::InstrW-1:0]        in_rdata_i,
  input  logic [if_pkg::AddrW-1:0]         in_addr_i,
  input  logic                             in_err_i,
  input  logic                             out_ready_i,
  output logic                             out_valid_o,
  output logic [if_pkg::InstrW-1:0]        out_rdata_o,
  output logic [if_pkg::AddrW-1:0]         out_addr_o,
  output logic                             out_err_o,
  output logic [$clog2(FifoDepth+1)-1:0]   count_o
);

  import if_pkg::*;

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic [InstrW-1:0]    rdata_q [FifoDepth];
  logic [AddrW-1:0]     addr_q  [FifoDepth];
  logic [FifoDepth-1:0] err_q;
  logic [PtrW-1:0]      wr_ptr_q;
  logic [PtrW-1:0]      rd_ptr_q;
  logic [CntW-1:0]      count_q;
  // address of the next word to be pushed
  logic [AddrW-1:0]     push_addr_q;
  logic                 pop;

  // wrap at the last slot, depth need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign out_valid_o = (count_q != '0);
  assign pop         = out_valid_o & out_ready_i;

  assign out_rdata_o = rdata_q[rd_ptr_q];
  assign out_addr_o  = addr_q[rd_ptr_q];
  assign out_err_o   = err_q[rd_ptr_q];
  assign count_o     = count_q;

  ////////////////////////////////////////////////////////////
  // pointers and running address
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      push_addr_q <= '0;
    end else if (flush_i) begin
      // drop everything and restart at the branch target
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      push_addr_q <= in_addr_i;
    end else begin
      if (in_valid_i) begin
        wr_ptr_q    <= ptr_inc(wr_ptr_q);
        push_addr_q <= push_addr_q + AddrW'(4);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + CntW'(in_valid_i) - CntW'(pop);
    end
  end

  // storage, the upstream budget keeps pushes within depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < FifoDepth; i++) begin
        rdata_q[i] <= '0;
        addr_q[i]  <= '0;
      end
      err_q <= '0;
    end else if (in_valid_i && !flush_i) begin
      rdata_q[wr_ptr_q] <= in_rdata_i;
      addr_q[wr_ptr_q]  <= push_addr_q;
      err_q[wr_ptr_q]   <= in_err_i;
    end
  end

endmodule

// File: verilog/if_id_regs.sv
/*
 * IF-ID pipeline register
 * holds the instruction for decode with valid/new flags and checks
 * that sequential fetches step by one word
 */

`timescale 1ns/100ps

module if_id_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_valid_i,
  input  logic [if_pkg::InstrW-1:0] fetch_rdata_i,
  input  logic [if_pkg::AddrW-1:0]  fetch_addr_i,
  input  logic                      fetch_err_i,
  input  logic                      id_in_ready_i,
  input  logic                      pc_set_i,
  input  logic                      instr_valid_clear_i,
  output logic                      fetch_ready_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic [if_pkg::InstrW-1:0] instr_rdata_id_o,
  output logic                      instr_fetch_err_o,
  output logic [if_pkg::AddrW-1:0]  pc_id_o,
  output logic                      pc_mismatch_alert_o
);

  import if_pkg::*;

  logic consume;
  logic valid_d;
  logic seq_q, seq_d;

  assign fetch_ready_o = id_in_ready_i;
  // a fetch taken alongside a pc set is squashed
  assign consume = fetch_valid_i & id_in_ready_i & ~pc_set_i;

  // valid sticks until decode clears it
  assign valid_d = consume | (instr_valid_id_o & ~instr_valid_clear_i);

  // no step check right after a redirect or a faulting fetch
  assign seq_d = (seq_q | consume) & ~pc_set_i & ~(fetch_valid_i & fetch_err_i);

  ////////////////////////////////////////////////////////////
  // pipeline registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      seq_q             <= 1'b0;
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= consume;
      seq_q            <= seq_d;
      // payload frozen while decode stalls
      if (consume) begin
        instr_rdata_id_o  <= fetch_rdata_i;
        instr_fetch_err_o <= fetch_err_i;
        pc_id_o           <= fetch_addr_i;
      end
    end
  end

  // next fetch must sit one word past the instruction in decode
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i &
                               (fetch_addr_i != pc_id_o + AddrW'(4));

endmodule

// File: verilog/if_pkg.sv
/*
 * instruction fetch package
 * widths, interrupt vector constants and the PC source encodings
 * shared by the fetch stage blocks
 */

package if_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // fetch address width
  parameter int unsigned AddrW = 32;
  // instruction word width, no compressed support
  parameter int unsigned InstrW = 32;
  // width of the interrupt vector index
  parameter int unsigned IrqVecW = 5;

  // every internal interrupt lands on this vector
  parameter int unsigned NmiVec = 31;

  ////////////////////////////////////////////////////////////
  // mux selects
  ////////////////////////////////////////////////////////////

  // source of the next fetch address on a pc set
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // exception target select
  typedef enum logic [1:0] {
    // synchronous exception, mtvec base
    EXC_PC_EXC,
    // vectored interrupt
    EXC_PC_IRQ,
    // debug mode entry
    EXC_PC_DBD,
    // exception while in debug mode
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

endpackage

// File: verilog/if_stage.sv
/*
 * instruction fetch stage
 * next pc selection, prefetch buffer and IF-ID register
 */

`timescale 1ns/100ps

module if_stage #(
  parameter logic [if_pkg::AddrW-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [if_pkg::AddrW-1:0] DmExceptionAddr = 32'h1A110808,
  parameter int unsigned              FifoDepth       = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [if_pkg::AddrW-1:0]   boot_addr_i,
  input  logic                       req_i,
  // instruction bus
  output logic                       instr_req_o,
  output logic [if_pkg::AddrW-1:0]   instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [if_pkg::InstrW-1:0]  instr_rdata_i,
  input  logic                       instr_bus_err_i,
  // towards decode
  output logic                       instr_valid_id_o,
  output logic                       instr_new_id_o,
  output logic [if_pkg::InstrW-1:0]  instr_rdata_id_o,
  output logic                       instr_fetch_err_o,
  output logic [if_pkg::AddrW-1:0]   pc_if_o,
  output logic [if_pkg::AddrW-1:0]   pc_id_o,
  // control from the controller
  input  logic                       instr_valid_clear_i,
  input  logic                       pc_set_i,
  input  if_pkg::pc_sel_e            pc_mux_i,
  input  if_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  logic [if_pkg::IrqVecW-1:0] exc_cause_i,
  input  logic                       exc_irq_int_i,
  input  logic [if_pkg::AddrW-1:0]   branch_target_i,
  output logic [if_pkg::AddrW-1:0]   pc_set_target_o,
  // csr values
  input  logic [if_pkg::AddrW-1:0]   csr_mepc_i,
  input  logic [if_pkg::AddrW-1:0]   csr_depc_i,
  input  logic [if_pkg::AddrW-1:0]   csr_mtvec_i,
  output logic                       csr_mtvec_init_o,
  input  logic                       id_in_ready_i,
  output logic                       pc_mismatch_alert_o,
  output logic                       if_busy_o
);

  import if_pkg::*;

  // fetch output of the prefetch buffer
  logic              fetch_valid;
  logic              fetch_ready;
  logic [InstrW-1:0] fetch_rdata;
  logic              fetch_err;

  // target address doubles as the branch address for the prefetcher
  pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .boot_addr_i      (boot_addr_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .exc_irq_int_i    (exc_irq_int_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_o     (pc_set_target_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // fetch address of the head entry is the IF pc
  prefetch_buffer #(
    .FifoDepth (FifoDepth)
  ) u_prefetch_buffer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (pc_set_target_o),
    .ready_i         (fetch_ready),
    .valid_o         (fetch_valid),
    .rdata_o         (fetch_rdata),
    .addr_o          (pc_if_o),
    .err_o           (fetch_err),
    .busy_o          (if_busy_o),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i)
  );

  if_id_regs u_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (pc_if_o),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

// File: verilog/pc_select.sv
/*
 * next pc selection
 * builds the exception target and picks the word aligned fetch address
 */

`timescale 1ns/100ps

module pc_select #(
  parameter logic [if_pkg::AddrW-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [if_pkg::AddrW-1:0] DmExceptionAddr = 32'h1A110808
) (
  input  logic [if_pkg::AddrW-1:0]   boot_addr_i,
  input  logic                       pc_set_i,
  input  if_pkg::pc_sel_e            pc_mux_i,
  input  if_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  logic [if_pkg::IrqVecW-1:0] exc_cause_i,
  input  logic                       exc_irq_int_i,
  input  logic [if_pkg::AddrW-1:0]   branch_target_i,
  input  logic [if_pkg::AddrW-1:0]   csr_mepc_i,
  input  logic [if_pkg::AddrW-1:0]   csr_depc_i,
  input  logic [if_pkg::AddrW-1:0]   csr_mtvec_i,
  output logic [if_pkg::AddrW-1:0]   fetch_addr_o,
  output logic                       csr_mtvec_init_o
);

  import if_pkg::*;

  logic [IrqVecW-1:0] irq_vec;
  logic [AddrW-1:0]   exc_pc;
  logic [AddrW-1:0]   next_pc;

  // internal interrupts all share the nmi vector
  assign irq_vec = exc_irq_int_i ? IrqVecW'(NmiVec) : exc_cause_i;

  ////////////////////////////////////////////////////////////
  // exception target
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      // direct mode, base only
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[AddrW-1:2], 2'b00};
      // vectored mode, 4 bytes per vector slot
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[AddrW-1:8], 1'b0, irq_vec, 2'b00};
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // fetch address mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT: next_pc = boot_addr_i;
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap handler
      PC_ERET: next_pc = csr_mepc_i;
      // return from debug mode
      PC_DRET: next_pc = csr_depc_i;
      default: next_pc = boot_addr_i;
    endcase
  end

  // every instruction is a full word
  assign fetch_addr_o = {next_pc[AddrW-1:2], 2'b00};

  // csr file loads its mtvec default on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// File: verilog/prefetch_buffer.sv
/*
 * prefetch buffer
 * runs the instruction bus, tracks outstanding requests and drops
 * responses that belong to a fetch stream abandoned by a branch
 */

`timescale 1ns/100ps

module prefetch_buffer #(
  parameter int unsigned FifoDepth = 3
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      branch_i,
  input  logic [if_pkg::AddrW-1:0]  branch_addr_i,
  input  logic                      ready_i,
  output logic                      valid_o,
  output logic [if_pkg::InstrW-1:0] rdata_o,
  output logic [if_pkg::AddrW-1:0]  addr_o,
  output logic                      err_o,
  output logic                      busy_o,
  // instruction bus
  output logic                      instr_req_o,
  output logic [if_pkg::AddrW-1:0]  instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [if_pkg::InstrW-1:0] instr_rdata_i,
  input  logic                      instr_bus_err_i
);

  import if_pkg::*;

  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic [AddrW-1:0] addr_q;
  // outstanding requests, at most two
  logic [1:0]       out_cnt_q, out_cnt_d;
  // one discard bit per outstanding request, bit 0 is the oldest
  logic [1:0]       discard_q, discard_d;
  logic [CntW-1:0]  fifo_cnt;
  logic [CntW-1:0]  fifo_cnt_eff;
  logic [CntW:0]    budget_used;
  logic             req_fire;
  logic             push;

  ////////////////////////////////////////////////////////////
  // request control
  ////////////////////////////////////////////////////////////

  // the FIFO empties on a branch so its entries stop counting at once
  assign fifo_cnt_eff = branch_i ? '0 : fifo_cnt;
  assign budget_used  = {{(CntW - 1){1'b0}}, out_cnt_q} + {1'b0, fifo_cnt_eff};

  assign instr_req_o  = req_i & (out_cnt_q != 2'd2) &
                        (budget_used < (CntW + 1)'(FifoDepth));
  // a branch goes straight to the bus in the same cycle
  assign instr_addr_o = branch_i ? branch_addr_i : addr_q;
  assign req_fire     = instr_req_o & instr_gnt_i;

  ////////////////////////////////////////////////////////////
  // outstanding request tracking
  ////////////////////////////////////////////////////////////

  always_comb begin
    out_cnt_d = out_cnt_q;
    discard_d = discard_q;
    // everything already on the bus belongs to the old stream
    if (branch_i) begin
      discard_d = 2'b11;
    end
    // oldest response retires
    if (instr_rvalid_i) begin
      discard_d = {1'b0, discard_d[1]};
      out_cnt_d = out_cnt_d - 2'd1;
    end
    // new grant is always kept
    if (req_fire) begin
      discard_d[out_cnt_d[0]] = 1'b0;
      out_cnt_d = out_cnt_d + 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q    <= '0;
      out_cnt_q <= '0;
      discard_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_d;
      discard_q <= discard_d;
      // address holds until granted
      if (req_fire) begin
        addr_q <= instr_addr_o + AddrW'(4);
      end else if (branch_i) begin
        addr_q <= branch_addr_i;
      end
    end
  end

  // a response in the branch cycle is from the old stream too
  assign push   = instr_rvalid_i & ~discard_q[0] & ~branch_i;
  assign busy_o = (out_cnt_q != 2'd0);

  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fetch_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (branch_i),
    .in_valid_i  (push),
    .in_rdata_i  (instr_rdata_i),
    .in_addr_i   (branch_addr_i),
    .in_err_i    (instr_bus_err_i),
    .out_ready_i (ready_i),
    .out_valid_o (valid_o),
    .out_rdata_o (rdata_o),
    .out_addr_o  (addr_o),
    .out_err_o   (err_o),
    .count_o     (fifo_cnt)
  );

endmodule
